// File: aes_stream.f
+incdir+include
hdl/aes_stream_pkg.sv
hdl/frame_if.sv
hdl/blk_bus_if.sv
hdl/block_ram.sv
hdl/word_gather.sv
hdl/keystream_gen.sv
hdl/block_mixer.sv
hdl/word_scatter.sv
hdl/aes_stream_top.sv
tests/aes_stream_tb.sv

// File: tests/aes_stream_tb.sv
`timescale 1ns/10ps
`include "aes_stream_consts.svh"

module tb_aes_stream;
        import aes_stream_pkg::*;

        localparam int NUM_RAND   = 60;
        localparam int NUM_FRAMES = NUM_RAND + 2;

        logic      s00_axis_aclk;
        logic      reset;
        logic      s00_axis_tvalid;
        logic      s00_axis_tready;
        word_t     s00_axis_tdata;
        logic      s00_axis_tlast;
        logic      m00_axis_tvalid;
        logic      m00_axis_tready;
        word_t     m00_axis_tdata;
        logic      m00_axis_tlast;

        // Expected output, one entry per word, oldest first
        word_t     exp_data_q[$];
        logic      exp_last_q[$];

        int        frame_blks [NUM_FRAMES];
        cmd_word_u frame_cmd  [NUM_FRAMES];
        bit        bp_on;
        int        total_words;

        aes_stream_top i_aes_stream_top (
                .s00_axis_aclk   (s00_axis_aclk),
                .reset           (reset),
                .s00_axis_tvalid (s00_axis_tvalid),
                .s00_axis_tready (s00_axis_tready),
                .s00_axis_tdata  (s00_axis_tdata),
                .s00_axis_tlast  (s00_axis_tlast),
                .m00_axis_tvalid (m00_axis_tvalid),
                .m00_axis_tready (m00_axis_tready),
                .m00_axis_tdata  (m00_axis_tdata),
                .m00_axis_tlast  (m00_axis_tlast)
        );

        initial begin
                s00_axis_aclk = 1'b0;
                forever #2 s00_axis_aclk = ~s00_axis_aclk;
        end

        // ====================================================================
        // Checking helpers and reference mask
        // ====================================================================

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
                        $display("=== FAIL ===");
                        $fatal(1, "value mismatch");
                end
        endtask

        task automatic abort_run(input string why);
                $display("%s at %0t", why, $time);
                $display("=== FAIL ===");
                $fatal(1, "run stopped");
        endtask

        // Word k of block n: seed XOR (4n+k), rotated left by 8k
        function automatic word_t model_mask(input cmd_word_u cmd, input int n, input int k);
                word_t v;

                if (cmd.fields.bypass) begin
                        return '0;
                end
                v = {8'h00, cmd.fields.seed} ^ word_t'(4 * n + k);
                if (k == 0) begin
                        return v;
                end
                return (v << (8 * k)) | (v >> (32 - 8 * k));
        endfunction

        // ====================================================================
        // Input side
        // ====================================================================

        // Entered and left at 1 ns after a rising edge
        task automatic send_word(input word_t data, input logic last);
                int   gap;
                logic accepted;

                gap = (bp_on && ($urandom % 4 == 0)) ? ($urandom % 3 + 1) : 0;
                repeat (gap) begin
                        s00_axis_tvalid = 1'b0;
                        @(posedge s00_axis_aclk);
                        #1;
                end
                s00_axis_tvalid = 1'b1;
                s00_axis_tdata = data;
                s00_axis_tlast = last;
                do begin
                        @(negedge s00_axis_aclk);
                        accepted = s00_axis_tready;
                        @(posedge s00_axis_aclk);
                        #1;
                end while (!accepted);
                s00_axis_tvalid = 1'b0;
                s00_axis_tlast = 1'b0;
        endtask

        task automatic send_frame(input int f);
                word_t words[$];
                word_t payload;

                for (int n = 0; n < frame_blks[f]; n++) begin
                        for (int k = 0; k < `WORDS_PER_BLK; k++) begin
                                payload = $urandom;
                                words.push_back(payload);
                                exp_data_q.push_back(payload ^ model_mask(frame_cmd[f], n, k));
                                exp_last_q.push_back(n == frame_blks[f] - 1 &&
                                                     k == `WORDS_PER_BLK - 1);
                        end
                end
                send_word(frame_cmd[f].raw, 1'b0);
                for (int i = 0; i < words.size(); i++) begin
                        send_word(words[i], i == words.size() - 1);
                end
        endtask

        // ====================================================================
        // Output side
        // ====================================================================

        initial begin
                m00_axis_tready = 1'b1;
                forever begin
                        @(posedge s00_axis_aclk);
                        #1;
                        m00_axis_tready = bp_on ? ($urandom % 3 != 0) : 1'b1;
                end
        end

        // Samples mid-cycle, the values the next rising edge will see
        initial begin
                logic  held_v;
                word_t held_d;
                logic  held_l;

                held_v = 1'b0;
                wait (reset === 1'b0);
                forever begin
                        @(negedge s00_axis_aclk);
                        if (held_v) begin
                                check_value("m00_axis_tvalid held", m00_axis_tvalid, 1);
                                check_value("m00_axis_tdata held", m00_axis_tdata, held_d);
                                check_value("m00_axis_tlast held", m00_axis_tlast, held_l);
                        end
                        if (m00_axis_tvalid && m00_axis_tready) begin
                                if (exp_data_q.size() == 0) begin
                                        abort_run("Output word arrived with none expected");
                                end
                                check_value("m00_axis_tdata", m00_axis_tdata,
                                            exp_data_q.pop_front());
                                check_value("m00_axis_tlast", m00_axis_tlast,
                                            exp_last_q.pop_front());
                        end
                        held_v = m00_axis_tvalid && !m00_axis_tready;
                        held_d = m00_axis_tdata;
                        held_l = m00_axis_tlast;
                end
        end

        // ====================================================================
        // Main sequence
        // ====================================================================

        initial begin
                void'($urandom(32'hd97433af));
                reset = 1'b1;
                s00_axis_tvalid = 1'b0;
                s00_axis_tdata = '0;
                s00_axis_tlast = 1'b0;
                bp_on = 1'b0;

                // Masked single block, then a bypass frame, then random frames
                frame_blks[0] = 1;
                frame_cmd[0].raw = $urandom;
                frame_cmd[0].fields.bypass = 1'b0;
                frame_blks[1] = 2;
                frame_cmd[1].raw = $urandom;
                frame_cmd[1].fields.bypass = 1'b1;
                for (int f = 2; f < NUM_FRAMES; f++) begin
                        frame_blks[f] = $urandom_range(1, `BUF_BLKS);
                        frame_cmd[f].raw = $urandom;
                        frame_cmd[f].fields.bypass = ($urandom % 5 == 0);
                end
                total_words = 0;
                for (int f = 0; f < NUM_FRAMES; f++) begin
                        total_words += 1 + `WORDS_PER_BLK * frame_blks[f];
                end

                fork
                        begin
                                repeat (total_words * 64 + 200) @(posedge s00_axis_aclk);
                                abort_run("Timeout, output stream never finished");
                        end
                join_none

                repeat (10) begin
                        @(posedge s00_axis_aclk);
                        #1;
                        check_value("m00_axis_tvalid", m00_axis_tvalid, 0);
                end
                reset = 1'b0;
                @(negedge s00_axis_aclk);
                check_value("s00_axis_tready", s00_axis_tready, 1);
                check_value("m00_axis_tvalid", m00_axis_tvalid, 0);
                @(posedge s00_axis_aclk);
                #1;

                send_frame(0);
                send_frame(1);
                bp_on = 1'b1;
                for (int f = 2; f < NUM_FRAMES; f++) begin
                        send_frame(f);
                end

                while (exp_data_q.size() != 0) begin
                        @(posedge s00_axis_aclk);
                end
                // Catch any extra words after the last frame
                repeat (40) @(posedge s00_axis_aclk);
                $display("=== PASS ===");
                $finish;
        end

endmodule

// File: hdl/aes_stream_top.sv
`timescale 1ns/10ps

module aes_stream_top (
        input  logic                  s00_axis_aclk,
        input  logic                  reset,

        // Slave side, command word then payload blocks
        input  logic                  s00_axis_tvalid,
        output logic                  s00_axis_tready,
        input  aes_stream_pkg::word_t s00_axis_tdata,
        input  logic                  s00_axis_tlast,

        // Master side, masked payload
        output logic                  m00_axis_tvalid,
        input  logic                  m00_axis_tready,
        output aes_stream_pkg::word_t m00_axis_tdata,
        output logic                  m00_axis_tlast
);
        import aes_stream_pkg::*;

        // Buffer write side
        logic     wr_en;
        blk_idx_t wr_addr;
        blk_t     wr_data;

        // Buffer read side and keystream
        logic     rd_en;
        blk_idx_t rd_addr;
        blk_t     rd_data;
        blk_idx_t ks_idx;
        blk_t     ks_mask;

        frame_if   frm_bus ();
        blk_bus_if blk_bus ();

        word_gather i_word_gather (
                .s00_axis_aclk   (s00_axis_aclk),
                .reset           (reset),
                .s00_axis_tvalid (s00_axis_tvalid),
                .s00_axis_tready (s00_axis_tready),
                .s00_axis_tdata  (s00_axis_tdata),
                .s00_axis_tlast  (s00_axis_tlast),
                .wr_en           (wr_en),
                .wr_addr         (wr_addr),
                .wr_data         (wr_data),
                .frm             (frm_bus.gather)
        );

        block_ram i_block_ram (
                .s00_axis_aclk (s00_axis_aclk),
                .wr_en         (wr_en),
                .wr_addr       (wr_addr),
                .wr_data       (wr_data),
                .rd_en         (rd_en),
                .rd_addr       (rd_addr),
                .rd_data       (rd_data)
        );

        keystream_gen i_keystream_gen (
                .s00_axis_aclk (s00_axis_aclk),
                .cmd           (frm_bus.cmd),
                .blk_idx       (ks_idx),
                .mask          (ks_mask)
        );

        block_mixer i_block_mixer (
                .s00_axis_aclk (s00_axis_aclk),
                .reset         (reset),
                .frm           (frm_bus.mixer),
                .rd_en         (rd_en),
                .rd_addr       (rd_addr),
                .rd_data       (rd_data),
                .ks_idx        (ks_idx),
                .ks_mask       (ks_mask),
                .obus          (blk_bus.source)
        );

        word_scatter i_word_scatter (
                .s00_axis_aclk   (s00_axis_aclk),
                .reset           (reset),
                .ibus            (blk_bus.sink),
                .m00_axis_tvalid (m00_axis_tvalid),
                .m00_axis_tready (m00_axis_tready),
                .m00_axis_tdata  (m00_axis_tdata),
                .m00_axis_tlast  (m00_axis_tlast)
        );

endmodule

// File: hdl/word_scatter.sv
`timescale 1ns/10ps
`include "aes_stream_consts.svh"

module word_scatter (
        input  logic                  s00_axis_aclk,
        input  logic                  reset,

        blk_bus_if.sink               ibus,

        output logic                  m00_axis_tvalid,
        input  logic                  m00_axis_tready,
        output aes_stream_pkg::word_t m00_axis_tdata,
        output logic                  m00_axis_tlast
);
        import aes_stream_pkg::*;

        blk_t       blk_r;
        logic       last_r;
        logic [1:0] word_cnt;
        logic       final_word;
        logic       take;

        assign final_word = (word_cnt == 2'(`WORDS_PER_BLK - 1));

        // Idle or the last word leaving this cycle
        assign ibus.ready = !m00_axis_tvalid || (m00_axis_tready && final_word);
        assign take = ibus.valid && ibus.ready;

        // ====================================================================
        // Word select with the most significant word first
        // ====================================================================

        assign m00_axis_tdata = blk_r[`BLK_W-1-word_cnt*`WORD_W -: `WORD_W];
        assign m00_axis_tlast = last_r && final_word;

        always_ff @(posedge s00_axis_aclk) begin
                if (reset) begin
                        m00_axis_tvalid <= 1'b0;
                        word_cnt <= '0;
                end
                else if (take) begin
                        blk_r <= ibus.blk;
                        last_r <= ibus.last;
                        word_cnt <= '0;
                        m00_axis_tvalid <= 1'b1;
                end
                else if (m00_axis_tvalid && m00_axis_tready) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (final_word) begin
                                m00_axis_tvalid <= 1'b0;
                        end
                end
        end

endmodule

// File: hdl/block_mixer.sv
`timescale 1ns/10ps

module block_mixer (
        input  logic                     s00_axis_aclk,
        input  logic                     reset,

        frame_if.mixer                   frm,

        output logic                     rd_en,
        output aes_stream_pkg::blk_idx_t rd_addr,
        input  aes_stream_pkg::blk_t     rd_data,

        output aes_stream_pkg::blk_idx_t ks_idx,
        input  aes_stream_pkg::blk_t     ks_mask,

        blk_bus_if.source                obus
);
        import aes_stream_pkg::*;

        blk_cnt_t rd_cnt;
        logic     last_rd;
        logic     advance;

        // Read stage
        logic     s1_v;
        logic     s1_last;
        logic     s1_held;
        blk_t     s1_blk;
        blk_t     mixed;

        assign rd_addr = rd_cnt[$bits(blk_idx_t)-1:0];
        assign ks_idx = rd_addr;
        assign last_rd = (rd_cnt == blk_cnt_t'(frm.blk_count - 1'b1));

        // Output register free or handing off this cycle
        assign advance = !obus.valid || obus.ready;
        assign rd_en = frm.frame_valid && advance;
        assign frm.frame_taken = rd_en && last_rd;

        // Mask may move on while stalled, so a stalled block keeps its own copy
        assign mixed = s1_held ? s1_blk : (rd_data ^ ks_mask);

        always_ff @(posedge s00_axis_aclk) begin
                if (reset) begin
                        rd_cnt <= '0;
                        s1_v <= 1'b0;
                        s1_held <= 1'b0;
                        obus.valid <= 1'b0;
                end
                else begin
                        if (rd_en) begin
                                rd_cnt <= last_rd ? '0 : rd_cnt + 1'b1;
                                s1_last <= last_rd;
                        end

                        if (advance) begin
                                obus.valid <= s1_v;
                                if (s1_v) begin
                                        obus.blk <= mixed;
                                        obus.last <= s1_last;
                                end
                                s1_v <= rd_en;
                                s1_held <= 1'b0;
                        end
                        else if (s1_v && !s1_held) begin
                                s1_blk <= mixed;
                                s1_held <= 1'b1;
                        end
                end
        end

        a_blk_stable: assert property (@(posedge s00_axis_aclk) disable iff (reset)
                obus.valid && !obus.ready |=> $stable(obus.blk) && $stable(obus.last));

endmodule

// File: hdl/keystream_gen.sv
`timescale 1ns/10ps
`include "aes_stream_consts.svh"

module keystream_gen (
        input  logic                      s00_axis_aclk,
        input  aes_stream_pkg::cmd_word_u cmd,
        input  aes_stream_pkg::blk_idx_t  blk_idx,
        output aes_stream_pkg::blk_t      mask
);
        import aes_stream_pkg::*;

        // Seed XOR running word number, then rotate left by 8k
        function automatic word_t mask_word(input logic [23:0] seed, input blk_idx_t idx,
                                            input int unsigned k);
                word_t                   base;
                logic [2*`WORD_W-1:0]    twice;

                base = word_t'(seed) ^ word_t'(idx * `WORDS_PER_BLK + k);
                twice = {base, base};
                return twice[2*`WORD_W-1-8*k -: `WORD_W];
        endfunction

        // Registered to line up with the buffer read latency
        always_ff @(posedge s00_axis_aclk) begin
                for (int k = 0; k < `WORDS_PER_BLK; k++) begin
                        if (cmd.fields.bypass) begin
                                mask[`BLK_W-1-k*`WORD_W -: `WORD_W] <= '0;
                        end
                        else begin
                                mask[`BLK_W-1-k*`WORD_W -: `WORD_W] <=
                                        mask_word(cmd.fields.seed, blk_idx, k);
                        end
                end
        end

endmodule

// File: hdl/word_gather.sv
`timescale 1ns/10ps
`include "aes_stream_consts.svh"

module word_gather (
        input  logic                      s00_axis_aclk,
        input  logic                      reset,

        input  logic                      s00_axis_tvalid,
        output logic                      s00_axis_tready,
        input  aes_stream_pkg::word_t     s00_axis_tdata,
        input  logic                      s00_axis_tlast,

        output logic                      wr_en,
        output aes_stream_pkg::blk_idx_t  wr_addr,
        output aes_stream_pkg::blk_t      wr_data,

        frame_if.gather                   frm
);
        import aes_stream_pkg::*;

        localparam logic GET_CMD     = 1'b0;
        localparam logic GET_PAYLOAD = 1'b1;

        logic       state;
        logic [1:0] word_cnt;
        blk_cnt_t   blk_cnt;
        blk_t       blk_r;
        logic       last_wr;
        logic       hold;
        logic       accept;

        // Closed from the tlast block until the mixer takes the frame
        assign s00_axis_tready = !hold;
        assign accept = s00_axis_tvalid && s00_axis_tready;
        assign wr_data = blk_r;

        always_ff @(posedge s00_axis_aclk) begin
                if (reset) begin
                        state <= GET_CMD;
                        word_cnt <= '0;
                        blk_cnt <= '0;
                        last_wr <= 1'b0;
                        hold <= 1'b0;
                        wr_en <= 1'b0;
                        frm.frame_valid <= 1'b0;
                end
                else begin
                        wr_en <= 1'b0;

                        // Final block lands this cycle, publish the frame
                        if (last_wr) begin
                                frm.frame_valid <= 1'b1;
                                frm.blk_count <= blk_cnt;
                                blk_cnt <= '0;
                                last_wr <= 1'b0;
                        end

                        if (frm.frame_taken) begin
                                frm.frame_valid <= 1'b0;
                                hold <= 1'b0;
                        end

                        case (state)
                                GET_CMD: begin
                                        if (accept) begin
                                                frm.cmd.raw <= s00_axis_tdata;
                                                state <= GET_PAYLOAD;
                                        end
                                end
                                GET_PAYLOAD: begin
                                        if (accept) begin
                                                // MS word first, so shift in from the bottom
                                                blk_r <= {blk_r[`BLK_W-`WORD_W-1:0], s00_axis_tdata};
                                                word_cnt <= word_cnt + 1'b1;

                                                if (word_cnt == 2'(`WORDS_PER_BLK - 1)) begin
                                                        wr_en <= 1'b1;
                                                        wr_addr <= blk_cnt[`BLK_IDX_W-1:0];
                                                        blk_cnt <= blk_cnt + 1'b1;

                                                        if (s00_axis_tlast) begin
                                                                last_wr <= 1'b1;
                                                                hold <= 1'b1;
                                                                state <= GET_CMD;
                                                        end
                                                end
                                        end
                                end
                                default: state <= GET_CMD;
                        endcase
                end
        end

        // ====================================================================
        // Framing checks
        // ====================================================================

        // Partial blocks are not supported
        a_tlast_on_fourth: assert property (@(posedge s00_axis_aclk) disable iff (reset)
                accept && state == GET_PAYLOAD && s00_axis_tlast
                |-> word_cnt == 2'(`WORDS_PER_BLK - 1));

        // Frame must fit in the buffer
        a_frame_fits: assert property (@(posedge s00_axis_aclk) disable iff (reset)
                accept && state == GET_PAYLOAD && word_cnt == 2'(`WORDS_PER_BLK - 1)
                |-> blk_cnt < `BLK_CNT_W'(`BUF_BLKS));

endmodule

// File: hdl/block_ram.sv
`timescale 1ns/10ps
`include "aes_stream_consts.svh"

module block_ram (
        input  logic                     s00_axis_aclk,

        input  logic                     wr_en,
        input  aes_stream_pkg::blk_idx_t wr_addr,
        input  aes_stream_pkg::blk_t     wr_data,

        input  logic                     rd_en,
        input  aes_stream_pkg::blk_idx_t rd_addr,
        output aes_stream_pkg::blk_t     rd_data
);
        import aes_stream_pkg::*;

        blk_t mem [`BUF_BLKS];

        always_ff @(posedge s00_axis_aclk) begin
                if (wr_en) begin
                        mem[wr_addr] <= wr_data;
                end

                // Output holds between reads
                if (rd_en) begin
                        rd_data <= mem[rd_addr];
                end
        end

endmodule

// File: hdl/blk_bus_if.sv
`timescale 1ns/10ps

interface blk_bus_if;
        import aes_stream_pkg::*;

        logic valid;
        logic ready;
        blk_t blk;

        // Final block of the frame
        logic last;

        modport source (
                output valid,
                output blk,
                output last,
                input  ready
        );

        modport sink (
                input  valid,
                input  blk,
                input  last,
                output ready
        );

endinterface

// File: hdl/frame_if.sv
`timescale 1ns/10ps

interface frame_if;
        import aes_stream_pkg::*;

        // Frame sitting in the block buffer
        logic      frame_valid;
        blk_cnt_t  blk_count;
        cmd_word_u cmd;

        // Pulse when the last block read goes out
        logic      frame_taken;

        modport gather (
                output frame_valid,
                output blk_count,
                output cmd,
                input  frame_taken
        );

        modport mixer (
                input  frame_valid,
                input  blk_count,
                input  cmd,
                output frame_taken
        );

endinterface

// File: hdl/aes_stream_pkg.sv
`include "aes_stream_consts.svh"

package aes_stream_pkg;

        // ================================================================
        // Data words and buffer indexing
        // ================================================================

        typedef logic [`WORD_W-1:0] word_t;
        typedef logic [`BLK_W-1:0] blk_t;

        // Buffer address of one block
        typedef logic [`BLK_IDX_W-1:0] blk_idx_t;
        // Blocks in one frame, 1 to `BUF_BLKS
        typedef logic [`BLK_CNT_W-1:0] blk_cnt_t;

        // ================================================================
        // Command word
        // ================================================================

        typedef struct packed {
                logic        bypass;
                logic [6:0]  spare;
                logic [23:0] seed;
        } cmd_fields_t;

        // Raw word as captured, fields as decoded by the keystream
        typedef union packed {
                word_t       raw;
                cmd_fields_t fields;
        } cmd_word_u;

endpackage

// File: include/aes_stream_consts.svh
`ifndef AES_STREAM_CONSTS_SVH
`define AES_STREAM_CONSTS_SVH

// ========================================================================
// Stream and block geometry
// ========================================================================

// One AXI-Stream word
`define WORD_W          32
// Words per cipher block
`define WORDS_PER_BLK   4
`define BLK_W           128

// ========================================================================
// Block buffer sizing
// ========================================================================

`define BUF_BLKS        4
`define BLK_IDX_W       2
// One extra bit so a full buffer can be counted
`define BLK_CNT_W       3

`endif
